/* phy_mgmt_cfg.svh */
`ifndef PHY_MGMT_CFG_SVH
`define PHY_MGMT_CFG_SVH

// management bus widths.
`define PHY_MGMT_ADDR_W 9
`define PHY_MGMT_DATA_W 32

// register map.
`define PHY_LOOPBACK_ADDR 9'h061
`define PHY_SCRATCH_ADDR 9'h062
`define PHY_ID_ADDR 9'h000
`define PHY_ID_VALUE 32'h0000_54e5

// cycles of waitrequest before an access completes.
`define PHY_MGMT_WAIT 2

`define SERDES_W 10

`endif

/* phy_mgmt_pkg.sv */
`include "phy_mgmt_cfg.svh"

package phy_mgmt_pkg;

   typedef logic [`PHY_MGMT_ADDR_W-1:0] mgmt_addr_t;
   typedef logic [`PHY_MGMT_DATA_W-1:0] mgmt_data_t;
   typedef logic [`SERDES_W-1:0] serdes_word_t; // one 10b code group.

   typedef enum logic {
      lb_idle,
      lb_write_data
   } lb_state_t;

   typedef enum logic [1:0] {
      arb_idle,
      arb_host_busy,
      arb_lb_busy
   } arb_state_t;

   typedef enum logic [1:0] {
      regs_idle,
      regs_wait_cnt,
      regs_done
   } regs_state_t;

endpackage

/* loopback_ctrl_master.sv */
`timescale 1ns/1ps
`include "phy_mgmt_cfg.svh"

module loopback_ctrl_master
(
   input  logic                     clk,
   input  logic                     reset,
   output phy_mgmt_pkg::mgmt_addr_t phy_mgmt_address,
   output logic                     phy_mgmt_read,
   output logic                     phy_mgmt_write,
   output phy_mgmt_pkg::mgmt_data_t phy_mgmt_writedata,
   input  phy_mgmt_pkg::mgmt_data_t phy_mgmt_readdata,
   input  logic                     phy_mgmt_waitrequest,
   input  logic                     sd_loopback
);

   phy_mgmt_pkg::lb_state_t state;
   phy_mgmt_pkg::lb_state_t next_state;
   logic sd_sync1;
   logic sd_sync2;
   logic lb_level;
   logic bit_event;
   logic wr_done;

   // two-flop synchronizer plus last seen level.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         sd_sync1 <= 1'b0;
         sd_sync2 <= 1'b0;
         lb_level <= 1'b0;
      end
      else
      begin
         sd_sync1 <= sd_loopback;
         sd_sync2 <= sd_sync1;
         lb_level <= sd_sync2;
      end
   end

   assign wr_done = (state == phy_mgmt_pkg::lb_write_data) && !phy_mgmt_waitrequest;

   // a new edge always wins over a clear.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         bit_event <= 1'b0;
      else if (sd_sync2 != lb_level)
         bit_event <= 1'b1;
      else if (wr_done && (phy_mgmt_writedata[0] == lb_level))
         bit_event <= 1'b0; // stale writes leave it set.
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= phy_mgmt_pkg::lb_idle;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;
      case (state)
         phy_mgmt_pkg::lb_idle:
         begin
            if (bit_event)
               next_state = phy_mgmt_pkg::lb_write_data;
         end
         phy_mgmt_pkg::lb_write_data:
         begin
            if (!phy_mgmt_waitrequest)
               next_state = phy_mgmt_pkg::lb_idle;
         end
         default: next_state = phy_mgmt_pkg::lb_idle;
      endcase
   end

   // level captured when the write is launched.
   always_ff @(posedge clk)
   begin
      if ((state == phy_mgmt_pkg::lb_idle) && (next_state == phy_mgmt_pkg::lb_write_data))
         phy_mgmt_writedata <= {{(`PHY_MGMT_DATA_W-1){1'b0}}, lb_level};
   end

   assign phy_mgmt_write   = (state == phy_mgmt_pkg::lb_write_data);
   assign phy_mgmt_read    = 1'b0; // write-only master.
   assign phy_mgmt_address = phy_mgmt_write ? `PHY_LOOPBACK_ADDR : '0;

   wr_hold_a: assert property (@(posedge clk) disable iff (reset)
      (phy_mgmt_write && phy_mgmt_waitrequest)
         |=> (phy_mgmt_write && $stable(phy_mgmt_writedata)));

   // register block returns zero data on write completion.
   wr_resp_a: assert property (@(posedge clk) disable iff (reset)
      wr_done |-> (phy_mgmt_readdata == '0));

endmodule

/* phy_mgmt_arbiter.sv */
`timescale 1ns/1ps

module phy_mgmt_arbiter
(
   input  logic                     clk,
   input  logic                     reset,
   input  phy_mgmt_pkg::mgmt_addr_t host_address,
   input  logic                     host_read,
   input  logic                     host_write,
   input  phy_mgmt_pkg::mgmt_data_t host_writedata,
   output phy_mgmt_pkg::mgmt_data_t host_readdata,
   output logic                     host_waitrequest,
   input  phy_mgmt_pkg::mgmt_addr_t lb_address,
   input  logic                     lb_read,
   input  logic                     lb_write,
   input  phy_mgmt_pkg::mgmt_data_t lb_writedata,
   output phy_mgmt_pkg::mgmt_data_t lb_readdata,
   output logic                     lb_waitrequest,
   output phy_mgmt_pkg::mgmt_addr_t reg_address,
   output logic                     reg_read,
   output logic                     reg_write,
   output phy_mgmt_pkg::mgmt_data_t reg_writedata,
   input  phy_mgmt_pkg::mgmt_data_t reg_readdata,
   input  logic                     reg_waitrequest
);

   phy_mgmt_pkg::arb_state_t state;
   logic host_req;
   logic lb_req;
   logic grant_host;
   logic grant_lb;

   assign host_req = host_read || host_write;
   assign lb_req   = lb_read || lb_write;

   // idle grant is decided in the same cycle, host first.
   assign grant_host = (state == phy_mgmt_pkg::arb_host_busy) ||
                       ((state == phy_mgmt_pkg::arb_idle) && host_req);
   assign grant_lb   = (state == phy_mgmt_pkg::arb_lb_busy) ||
                       ((state == phy_mgmt_pkg::arb_idle) && !host_req && lb_req);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= phy_mgmt_pkg::arb_idle;
      else if (!reg_waitrequest)
         state <= phy_mgmt_pkg::arb_idle; // access completed, release.
      else if (grant_host)
         state <= phy_mgmt_pkg::arb_host_busy;
      else if (grant_lb)
         state <= phy_mgmt_pkg::arb_lb_busy;
   end

   always_comb
   begin
      reg_address   = '0;
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      reg_writedata = '0;
      if (grant_host)
      begin
         reg_address   = host_address;
         reg_read      = host_read;
         reg_write     = host_write;
         reg_writedata = host_writedata;
      end
      else if (grant_lb)
      begin
         reg_address   = lb_address;
         reg_read      = lb_read;
         reg_write     = lb_write;
         reg_writedata = lb_writedata;
      end
   end

   // the loser sees waitrequest and holds its request.
   assign host_waitrequest = grant_host ? reg_waitrequest : 1'b1;
   assign host_readdata    = grant_host ? reg_readdata : '0;
   assign lb_waitrequest   = grant_lb ? reg_waitrequest : 1'b1;
   assign lb_readdata      = grant_lb ? reg_readdata : '0;

   grant_lock_a: assert property (@(posedge clk) disable iff (reset)
      ((reg_read || reg_write) && reg_waitrequest) |=> $stable({grant_host, grant_lb}));

endmodule

/* phy_mgmt_regs.sv */
`timescale 1ns/1ps
`include "phy_mgmt_cfg.svh"

module phy_mgmt_regs
(
   input  logic                     clk,
   input  logic                     reset,
   input  phy_mgmt_pkg::mgmt_addr_t address,
   input  logic                     read,
   input  logic                     write,
   input  phy_mgmt_pkg::mgmt_data_t writedata,
   output phy_mgmt_pkg::mgmt_data_t readdata,
   output logic                     waitrequest,
   output logic                     serial_loopback
);

   localparam logic [3:0] wait_last = 4'(`PHY_MGMT_WAIT - 1);

   phy_mgmt_pkg::regs_state_t state;
   phy_mgmt_pkg::regs_state_t next_state;
   logic [3:0] wait_cnt_q;
   logic access;
   logic loopback_q;
   phy_mgmt_pkg::mgmt_data_t scratch_q;
   phy_mgmt_pkg::mgmt_data_t rd_mux;
   phy_mgmt_pkg::mgmt_data_t readdata_q;

   assign access = read || write;

   always_comb
   begin
      next_state = state;
      case (state)
         phy_mgmt_pkg::regs_idle:
         begin
            // idle cycle already counts as the first wait cycle.
            if (access)
               next_state = (`PHY_MGMT_WAIT > 1) ? phy_mgmt_pkg::regs_wait_cnt
                                                  : phy_mgmt_pkg::regs_done;
         end
         phy_mgmt_pkg::regs_wait_cnt:
         begin
            if (!access)
               next_state = phy_mgmt_pkg::regs_idle; // request withdrawn.
            else if (wait_cnt_q >= wait_last)
               next_state = phy_mgmt_pkg::regs_done;
         end
         phy_mgmt_pkg::regs_done: next_state = phy_mgmt_pkg::regs_idle;
         default: next_state = phy_mgmt_pkg::regs_idle;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state      <= phy_mgmt_pkg::regs_idle;
         wait_cnt_q <= 4'd1;
      end
      else
      begin
         state      <= next_state;
         wait_cnt_q <= (state == phy_mgmt_pkg::regs_wait_cnt) ? wait_cnt_q + 4'd1 : 4'd1;
      end
   end

   // writes commit in the completing cycle.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         loopback_q <= 1'b0;
         scratch_q  <= '0;
      end
      else if ((state == phy_mgmt_pkg::regs_done) && write)
      begin
         case (address)
            `PHY_LOOPBACK_ADDR: loopback_q <= writedata[0];
            `PHY_SCRATCH_ADDR: scratch_q <= writedata;
            default: ; // id and unmapped are dropped.
         endcase
      end
   end

   always_comb
   begin
      case (address)
         `PHY_ID_ADDR: rd_mux = `PHY_ID_VALUE;
         `PHY_LOOPBACK_ADDR: rd_mux = {{(`PHY_MGMT_DATA_W-1){1'b0}}, loopback_q};
         `PHY_SCRATCH_ADDR: rd_mux = scratch_q;
         default: rd_mux = '0;
      endcase
   end

   // loaded on entry to done, zero otherwise.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         readdata_q <= '0;
      else if ((next_state == phy_mgmt_pkg::regs_done) && read)
         readdata_q <= rd_mux;
      else
         readdata_q <= '0;
   end

   assign readdata        = readdata_q;
   assign waitrequest     = (state != phy_mgmt_pkg::regs_done);
   assign serial_loopback = loopback_q;

   rd_wr_excl_a: assert property (@(posedge clk) disable iff (reset)
      !(read && write));

endmodule

/* serdes_loopback_path.sv */
`timescale 1ns/1ps

module serdes_loopback_path
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       serial_loopback,
   input  phy_mgmt_pkg::serdes_word_t tx_data,
   input  phy_mgmt_pkg::serdes_word_t rx_serial,
   output phy_mgmt_pkg::serdes_word_t rx_data
);

   phy_mgmt_pkg::serdes_word_t tx_q;
   phy_mgmt_pkg::serdes_word_t rx_q;
   logic lb_sel_q;

   // one word per cycle, so every edge is a word boundary.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         lb_sel_q <= 1'b0;
      else
         lb_sel_q <= serial_loopback;
   end

   // both sources land on the same edge as the select.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tx_q <= '0;
         rx_q <= '0;
      end
      else
      begin
         tx_q <= tx_data; // looped-back copy.
         rx_q <= rx_serial;
      end
   end

   assign rx_data = lb_sel_q ? tx_q : rx_q;

endmodule

/* tse_phy_top.sv */
`timescale 1ns/1ps

module tse_phy_top
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       sd_loopback,
   input  phy_mgmt_pkg::mgmt_addr_t   host_address,
   input  logic                       host_read,
   input  logic                       host_write,
   input  phy_mgmt_pkg::mgmt_data_t   host_writedata,
   output phy_mgmt_pkg::mgmt_data_t   host_readdata,
   output logic                       host_waitrequest,
   input  phy_mgmt_pkg::serdes_word_t tx_data,
   input  phy_mgmt_pkg::serdes_word_t rx_serial,
   output phy_mgmt_pkg::serdes_word_t rx_data
);

   phy_mgmt_pkg::mgmt_addr_t lb_address;
   logic                     lb_read;
   logic                     lb_write;
   phy_mgmt_pkg::mgmt_data_t lb_writedata;
   phy_mgmt_pkg::mgmt_data_t lb_readdata;
   logic                     lb_waitrequest;
   phy_mgmt_pkg::mgmt_addr_t reg_address;
   logic                     reg_read;
   logic                     reg_write;
   phy_mgmt_pkg::mgmt_data_t reg_writedata;
   phy_mgmt_pkg::mgmt_data_t reg_readdata;
   logic                     reg_waitrequest;
   logic                     serial_loopback;

   loopback_ctrl_master loopback_ctrl_master_i (
      .clk                  (clk),
      .reset                (reset),
      .phy_mgmt_address     (lb_address),
      .phy_mgmt_read        (lb_read),
      .phy_mgmt_write       (lb_write),
      .phy_mgmt_writedata   (lb_writedata),
      .phy_mgmt_readdata    (lb_readdata),
      .phy_mgmt_waitrequest (lb_waitrequest),
      .sd_loopback          (sd_loopback)
   );

   phy_mgmt_arbiter phy_mgmt_arbiter_i (
      .clk              (clk),
      .reset            (reset),
      .host_address     (host_address),
      .host_read        (host_read),
      .host_write       (host_write),
      .host_writedata   (host_writedata),
      .host_readdata    (host_readdata),
      .host_waitrequest (host_waitrequest),
      .lb_address       (lb_address),
      .lb_read          (lb_read),
      .lb_write         (lb_write),
      .lb_writedata     (lb_writedata),
      .lb_readdata      (lb_readdata),
      .lb_waitrequest   (lb_waitrequest),
      .reg_address      (reg_address),
      .reg_read         (reg_read),
      .reg_write        (reg_write),
      .reg_writedata    (reg_writedata),
      .reg_readdata     (reg_readdata),
      .reg_waitrequest  (reg_waitrequest)
   );

   phy_mgmt_regs phy_mgmt_regs_i (
      .clk             (clk),
      .reset           (reset),
      .address         (reg_address),
      .read            (reg_read),
      .write           (reg_write),
      .writedata       (reg_writedata),
      .readdata        (reg_readdata),
      .waitrequest     (reg_waitrequest),
      .serial_loopback (serial_loopback)
   );

   serdes_loopback_path serdes_loopback_path_i (
      .clk             (clk),
      .reset           (reset),
      .serial_loopback (serial_loopback),
      .tx_data         (tx_data),
      .rx_serial       (rx_serial),
      .rx_data         (rx_data)
   );

endmodule

/* tb_tse_phy.sv */
`timescale 1ns/1ps
`include "phy_mgmt_cfg.svh"

module tb_tse_phy;

   typedef logic [8*32-1:0] tok_t;

   localparam int max_polls = 12;
   localparam int cycles_per_case = 40;
   localparam tok_t tok_hash = tok_t'("#");
   localparam tok_t tok_wr = tok_t'("wr");
   localparam tok_t tok_rd = tok_t'("rd");
   localparam tok_t tok_lb = tok_t'("lb");
   localparam tok_t tok_dp = tok_t'("dp");
   localparam tok_t tok_ct = tok_t'("ct");
   localparam tok_t tok_rnd = tok_t'("rnd");
   localparam tok_t tok_last = tok_t'("last");
   localparam tok_t tok_tx = tok_t'("tx");

   logic clk;
   logic reset;
   logic sd_loopback;
   phy_mgmt_pkg::mgmt_addr_t host_address;
   logic host_read;
   logic host_write;
   phy_mgmt_pkg::mgmt_data_t host_writedata;
   phy_mgmt_pkg::mgmt_data_t host_readdata;
   logic host_waitrequest;
   phy_mgmt_pkg::serdes_word_t tx_data;
   phy_mgmt_pkg::serdes_word_t rx_serial;
   phy_mgmt_pkg::serdes_word_t rx_data;

   integer seed;
   int cycle_cnt = 0;
   int cycle_limit = 0;
   phy_mgmt_pkg::mgmt_data_t scratch_model; // last word written to 0x62.

   tse_phy_top tse_phy_top_i (
      .clk              (clk),
      .reset            (reset),
      .sd_loopback      (sd_loopback),
      .host_address     (host_address),
      .host_read        (host_read),
      .host_write       (host_write),
      .host_writedata   (host_writedata),
      .host_readdata    (host_readdata),
      .host_waitrequest (host_waitrequest),
      .tx_data          (tx_data),
      .rx_serial        (rx_serial),
      .rx_data          (rx_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
      begin
         $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic check_value(input tok_t name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %0s expected %h actual %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "value check failed");
      end
   endtask

   function automatic phy_mgmt_pkg::mgmt_data_t to_word(input tok_t tok);
      phy_mgmt_pkg::mgmt_data_t v;
      logic [7:0] c;
      v = '0;
      for (int i = 31; i >= 0; i--)
      begin
         c = tok[i*8 +: 8];
         if ((c >= "0") && (c <= "9"))
            v = {v[27:0], c[3:0]};
         else if ((c >= "a") && (c <= "f"))
            v = {v[27:0], c[3:0] + 4'd9};
      end
      return v;
   endfunction

   function automatic phy_mgmt_pkg::mgmt_data_t data_value(input tok_t tok);
      if (tok == tok_rnd)
         return $random(seed);
      else
         return to_word(tok);
   endfunction

   // one Avalon access with waitrequest sampled mid-cycle.
   task automatic bus_access(input logic is_write, input phy_mgmt_pkg::mgmt_addr_t addr,
                             input phy_mgmt_pkg::mgmt_data_t wdata,
                             output phy_mgmt_pkg::mgmt_data_t rdata,
                             output int n_cycles);
      @(negedge clk);
      host_address   = addr;
      host_read      = !is_write;
      host_write     = is_write;
      host_writedata = wdata;
      @(negedge clk);
      n_cycles = 2; // rising edges up to the completing one.
      while (host_waitrequest)
      begin
         n_cycles = n_cycles + 1;
         @(negedge clk);
      end
      rdata = host_readdata; // completing cycle.
      @(negedge clk);
      host_read  = 1'b0;
      host_write = 1'b0;
   endtask

   task automatic poll_loopback(input tok_t name, input phy_mgmt_pkg::mgmt_addr_t addr,
                                input logic level);
      phy_mgmt_pkg::mgmt_data_t rdata;
      phy_mgmt_pkg::mgmt_data_t expected;
      int polls;
      int n_cycles;
      expected = {{(`PHY_MGMT_DATA_W-1){1'b0}}, level};
      polls    = 0;
      bus_access(1'b0, addr, '0, rdata, n_cycles);
      while ((rdata !== expected) && (polls < max_polls))
      begin
         polls = polls + 1;
         bus_access(1'b0, addr, '0, rdata, n_cycles);
      end
      check_value(name, expected, rdata);
   endtask

   task automatic read_case(input integer fd, output logic got, output tok_t op,
                            output tok_t addr_s, output tok_t data_s,
                            output tok_t exp_s, output tok_t name_s);
      integer code;
      logic done;
      logic [8*128-1:0] skip;
      got  = 1'b0;
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, "%s", op);
         if (code != 1)
            done = 1'b1;
         else if (op == tok_hash)
            code = $fgets(skip, fd); // column notes.
         else
         begin
            code = $fscanf(fd, "%s %s %s %s", addr_s, data_s, exp_s, name_s);
            got  = (code == 4);
            done = 1'b1;
         end
      end
   endtask

   task automatic run_case(input tok_t op, input tok_t addr_s, input tok_t data_s,
                           input tok_t exp_s, input tok_t name_s);
      phy_mgmt_pkg::mgmt_addr_t addr;
      phy_mgmt_pkg::mgmt_data_t wdata;
      phy_mgmt_pkg::mgmt_data_t expected;
      phy_mgmt_pkg::mgmt_data_t rdata;
      phy_mgmt_pkg::serdes_word_t tx_word;
      phy_mgmt_pkg::serdes_word_t rx_word;
      int n_cycles;
      wdata    = to_word(addr_s);
      addr     = wdata[`PHY_MGMT_ADDR_W-1:0];
      expected = (exp_s == tok_last) ? scratch_model : to_word(exp_s);
      if ((op == tok_wr) || (op == tok_ct))
      begin
         wdata = data_value(data_s);
         if (op == tok_ct)
         begin
            @(negedge clk);
            sd_loopback = expected[0];
            repeat (3) @(negedge clk); // lands on the master's write.
         end
         bus_access(1'b1, addr, wdata, rdata, n_cycles);
         if (addr == `PHY_SCRATCH_ADDR)
            scratch_model = wdata;
         if (op == tok_ct)
            poll_loopback(name_s, `PHY_LOOPBACK_ADDR, expected[0]);
         else
            check_value(name_s, `PHY_MGMT_WAIT + 1, n_cycles); // uncontested write.
      end
      else if (op == tok_rd)
      begin
         bus_access(1'b0, addr, '0, rdata, n_cycles);
         check_value(name_s, expected, rdata);
         check_value(name_s, `PHY_MGMT_WAIT + 1, n_cycles); // uncontested read.
      end
      else if (op == tok_lb)
      begin
         wdata = to_word(data_s);
         @(negedge clk);
         sd_loopback = wdata[0];
         poll_loopback(name_s, addr, expected[0]);
      end
      else if (op == tok_dp)
      begin
         wdata   = data_value(data_s);
         tx_word = wdata[`SERDES_W-1:0];
         wdata   = data_value(data_s);
         rx_word = wdata[`SERDES_W-1:0];
         @(negedge clk);
         tx_data   = tx_word;
         rx_serial = rx_word;
         @(negedge clk);
         check_value(name_s, {{(`PHY_MGMT_DATA_W-`SERDES_W){1'b0}},
                              (exp_s == tok_tx) ? tx_word : rx_word},
                     {{(`PHY_MGMT_DATA_W-`SERDES_W){1'b0}}, rx_data});
      end
      else
      begin
         $display("unknown operation %0s in step %0s of the case file", op, name_s);
         $display("Simulation failed");
         $fatal(1, "bad case file");
      end
   endtask

   initial
   begin
      integer fd;
      logic got;
      int n_cases;
      tok_t op;
      tok_t addr_s;
      tok_t data_s;
      tok_t exp_s;
      tok_t name_s;
      seed           = 32'hdef3;
      reset          = 1'b1;
      sd_loopback    = 1'b0;
      host_address   = '0;
      host_read      = 1'b0;
      host_write     = 1'b0;
      host_writedata = '0;
      tx_data        = '0;
      rx_serial      = '0;
      scratch_model  = '0;

      // first pass only counts steps.
      fd = $fopen("phy_mgmt_cases.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open phy_mgmt_cases.txt");
         $display("Simulation failed");
         $fatal(1, "missing case file");
      end
      n_cases = 0;
      read_case(fd, got, op, addr_s, data_s, exp_s, name_s);
      while (got)
      begin
         n_cases = n_cases + 1;
         read_case(fd, got, op, addr_s, data_s, exp_s, name_s);
      end
      $fclose(fd);
      if (n_cases == 0)
      begin
         $display("phy_mgmt_cases.txt holds no test steps");
         $display("Simulation failed");
         $fatal(1, "empty case file");
      end
      cycle_limit = cycles_per_case * n_cases;

      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      fd = $fopen("phy_mgmt_cases.txt", "r");
      read_case(fd, got, op, addr_s, data_s, exp_s, name_s);
      while (got)
      begin
         run_case(op, addr_s, data_s, exp_s, name_s);
         read_case(fd, got, op, addr_s, data_s, exp_s, name_s);
      end
      $fclose(fd);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* compile.f */
+incdir+.
phy_mgmt_pkg.sv
loopback_ctrl_master.sv
phy_mgmt_arbiter.sv
phy_mgmt_regs.sv
serdes_loopback_path.sv
tse_phy_top.sv
tb_tse_phy.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the PHY management testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module tb_tse_phy \
   --Mdir obj_dir \
   -o tb_tse_phy \
   -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build returned status $status"
   exit "$status"
fi

./obj_dir/tb_tse_phy
status=$?
if [ "$status" -ne 0 ]; then
   echo "testbench run returned status $status"
   exit "$status"
fi

echo "testbench run returned status 0"
exit 0

/* phy_mgmt_cases.txt */
# columns: op addr data expected name, op is wr rd lb dp or ct, numbers in hex, - is unused
# rnd is a random word, last is the last word written to 0x062, dp expects tx or rx
rd 000 - 000054e5 id_after_reset
rd 061 - 00000000 loopback_after_reset
rd 062 - 00000000 scratch_after_reset
rd 1ff - 00000000 unmapped_after_reset
wr 062 rnd - scratch_wr_1
rd 062 - last scratch_rd_1
wr 062 a5a5f00f - scratch_wr_2
rd 062 - a5a5f00f scratch_rd_2
wr 062 rnd - scratch_wr_3
rd 062 - last scratch_rd_3
wr 063 deadbeef - unmapped_wr
rd 063 - 00000000 unmapped_rd
wr 100 ffffffff - unmapped_wr_high
rd 100 - 00000000 unmapped_rd_high
rd 062 - last scratch_kept
wr 000 12345678 - id_wr
rd 000 - 000054e5 id_unchanged
dp - rnd rx dp_off_1
dp - rnd rx dp_off_2
dp - rnd rx dp_off_3
lb 061 1 1 loopback_on
rd 061 - 00000001 loopback_on_rd
dp - rnd tx dp_on_1
dp - rnd tx dp_on_2
dp - rnd tx dp_on_3
lb 061 0 0 loopback_off
dp - rnd rx dp_off_4
dp - rnd rx dp_off_5
ct 062 rnd 1 contend_on
rd 062 - last contend_on_scratch
rd 061 - 00000001 contend_on_lb
dp - rnd tx dp_on_4
ct 062 rnd 0 contend_off
rd 062 - last contend_off_scratch
rd 061 - 00000000 contend_off_lb
dp - rnd rx dp_off_6
lb 061 1 1 loopback_on_again
rd 062 - last scratch_final
